// File: logic/rdma_flow_pkg.sv
`default_nettype none

package rdma_flow_pkg;

    // Request key fields
    localparam int REGION_BITS = 2;
    localparam int PID_BITS    = 4;

    // Direction bit on top of region and pid
    localparam int KEY_BITS = 1 + REGION_BITS + PID_BITS;

    localparam int LEN_BITS = 16;

    // Stored window word, only the low bits carry pointers
    localparam int PTR_BITS = 16;

    typedef logic [REGION_BITS-1:0] region_t;
    typedef logic [PID_BITS-1:0]    pid_t;
    typedef logic [KEY_BITS-1:0]    key_t;
    typedef logic [LEN_BITS-1:0]    len_t;

    // Layout from the lsb: tail, head, issued flag
    typedef logic [PTR_BITS-1:0] ptr_word_t;

    // Flow control FSM
    typedef enum logic [2:0] {
        ST_CLEAR,
        ST_IDLE,
        ST_ACK_WAIT,
        ST_REQ_WAIT,
        ST_ACK_LUP,
        ST_REQ_LUP
    } flow_state_t;

endpackage

`default_nettype wire

// File: logic/ssn_table.sv
`timescale 1ns/100ps
`default_nettype none

module ssn_table
    import rdma_flow_pkg::*;
#(
    parameter int ADDR_BITS = KEY_BITS,
    parameter int DATA_BITS = PTR_BITS
) (
    input  wire            aclk,
    input  wire            we,
    input  wire key_t      addr,
    input  wire ptr_word_t wdata,
    output ptr_word_t      rdata
);

// One window word per key
logic [DATA_BITS-1:0] mem [2**ADDR_BITS];
logic [DATA_BITS-1:0] rd_q;

// Registered read, a write returns the new word
always_ff @(posedge aclk) begin
    if (we) begin
        mem[addr[ADDR_BITS-1:0]] <= wdata[DATA_BITS-1:0];
        rd_q <= wdata[DATA_BITS-1:0];
    end else begin
        rd_q <= mem[addr[ADDR_BITS-1:0]];
    end
end

// Unused upper bits read as zero
assign rdata = ptr_word_t'(rd_q);

endmodule

`default_nettype wire

// File: logic/meta_queue.sv
`timescale 1ns/100ps
`default_nettype none

module meta_queue #(
    parameter int QDEPTH = 8,
    parameter int WIDTH  = 32
) (
    input  wire              aclk,
    input  wire              aresetn,

    input  wire              s_valid,
    output logic             s_ready,
    input  wire [WIDTH-1:0]  s_data,

    output logic             m_valid,
    input  wire              m_ready,
    output logic [WIDTH-1:0] m_data
);

localparam int AW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
localparam int CW = $clog2(QDEPTH + 1);

logic [WIDTH-1:0] mem [QDEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [CW-1:0] count;
logic push;
logic pop;

assign s_ready = (count != CW'(QDEPTH));
assign m_valid = (count != '0);
assign push = s_valid && s_ready;
assign pop = m_valid && m_ready;

// Head word is visible without a read cycle
assign m_data = mem[rd_ptr];

always_ff @(posedge aclk) begin
    if (push) begin
        mem[wr_ptr] <= s_data;
    end
end

always_ff @(posedge aclk) begin
    if (!aresetn) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == AW'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == AW'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

// The writer never offers a word to a full queue
a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
    s_valid |-> s_ready);

// Empty means both pointers meet
a_empty_ptrs: assert property (@(posedge aclk) disable iff (!aresetn)
    (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

`default_nettype wire

// File: logic/rdma_flow.sv
`timescale 1ns/100ps
`default_nettype none

module rdma_flow
    import rdma_flow_pkg::*;
#(
    parameter int N_OST = 8,
    localparam int OST_BITS = $clog2(N_OST),
    localparam int RQ_BITS = 1 + REGION_BITS + PID_BITS + LEN_BITS + OST_BITS
) (
    input  wire               aclk,
    input  wire               aresetn,

    input  wire               s_req_valid,
    output logic              s_req_ready,
    input  wire               s_req_rd,
    input  wire region_t      s_req_region,
    input  wire pid_t         s_req_pid,
    input  wire len_t         s_req_len,

    input  wire               s_ack_valid,
    output logic              s_ack_ready,
    input  wire               s_ack_rd,
    input  wire region_t      s_ack_region,
    input  wire pid_t         s_ack_pid,
    input  wire               s_ack_last,

    output logic              tbl_we,
    output key_t              tbl_addr,
    output ptr_word_t         tbl_wdata,
    input  wire ptr_word_t    tbl_rdata,

    output logic              rq_valid,
    input  wire               rq_ready,
    output logic [RQ_BITS-1:0] rq_data,

    output logic              aq_valid,
    input  wire               aq_ready,
    output key_t              aq_data
);

flow_state_t state_q, state_d;
key_t clr_cnt_q;
key_t key_q;

// Request fields held for the push
logic    req_rd_q;
region_t req_region_q;
pid_t    req_pid_q;
len_t    req_len_q;

key_t ack_key;
key_t req_key;
logic ack_take;
logic req_start;
logic admit;

logic [OST_BITS-1:0] head, head_n;
logic [OST_BITS-1:0] tail, tail_n;
logic issued, issued_n;

assign ack_key = {s_ack_rd, s_ack_region, s_ack_pid};
assign req_key = {s_req_rd, s_req_region, s_req_pid};

// Acks win, a request needs room in the request queue
assign ack_take = (state_q == ST_IDLE) && s_ack_valid && aq_ready;
assign req_start = (state_q == ST_IDLE) && !s_ack_valid && s_req_valid && rq_ready;

assign tail = tbl_rdata[0 +: OST_BITS];
assign head = tbl_rdata[OST_BITS +: OST_BITS];
assign issued = tbl_rdata[2*OST_BITS];

// Window has room unless head caught up with tail while issued
assign admit = (state_q == ST_REQ_LUP) && (!issued || (head != tail));

always_ff @(posedge aclk) begin
    if (!aresetn) begin
        state_q <= ST_CLEAR;
        clr_cnt_q <= '0;
    end else begin
        state_q <= state_d;
        if (state_q == ST_CLEAR) begin
            clr_cnt_q <= clr_cnt_q + 1'b1;
        end
    end
end

always_ff @(posedge aclk) begin
    if (ack_take) begin
        key_q <= ack_key;
    end else if (req_start) begin
        key_q <= req_key;
        req_rd_q <= s_req_rd;
        req_region_q <= s_req_region;
        req_pid_q <= s_req_pid;
        req_len_q <= s_req_len;
    end
end

always_comb begin
    state_d = state_q;
    case (state_q)
        ST_CLEAR: begin
            if (clr_cnt_q == '1) begin
                state_d = ST_IDLE;
            end
        end
        ST_IDLE: begin
            if (ack_take) begin
                state_d = ST_ACK_WAIT;
            end else if (req_start) begin
                state_d = ST_REQ_WAIT;
            end
        end
        ST_ACK_WAIT: state_d = ST_ACK_LUP;
        ST_REQ_WAIT: state_d = ST_REQ_LUP;
        ST_ACK_LUP:  state_d = ST_IDLE;
        ST_REQ_LUP:  state_d = ST_IDLE;
        default:     state_d = ST_CLEAR;
    endcase
end

// Pointer update
always_comb begin
    head_n = head;
    tail_n = tail;
    issued_n = issued;
    if (state_q == ST_ACK_LUP) begin
        tail_n = tail + 1'b1;
        if (tail_n == head) begin
            issued_n = 1'b0;
        end
    end else if (admit) begin
        head_n = head + 1'b1;
        issued_n = 1'b1;
    end
end

// Table port, the key stays on the address through the lookup
always_comb begin
    tbl_we = 1'b0;
    tbl_addr = key_q;
    tbl_wdata = ptr_word_t'({issued_n, head_n, tail_n});
    case (state_q)
        ST_CLEAR: begin
            tbl_we = 1'b1;
            tbl_addr = clr_cnt_q;
            tbl_wdata = '0;
        end
        ST_IDLE:    tbl_addr = ack_take ? ack_key : req_key;
        ST_ACK_LUP: tbl_we = 1'b1;
        ST_REQ_LUP: tbl_we = admit;
        default:    tbl_we = 1'b0;
    endcase
end

assign s_ack_ready = ack_take;
assign aq_valid = ack_take && s_ack_last;
assign aq_data = ack_key;

assign s_req_ready = admit;
assign rq_valid = admit;
assign rq_data = {req_rd_q, req_region_q, req_pid_q, req_len_q, head};

// Acks only retire issued entries
a_ack_issued: assert property (@(posedge aclk) disable iff (!aresetn)
    (state_q == ST_ACK_LUP) |-> issued);

// Room in the request queue was reserved at the IDLE decision
a_req_ready_room: assert property (@(posedge aclk) disable iff (!aresetn)
    s_req_ready |-> s_req_valid && rq_ready);

// Write-back goes to the entry chosen at the IDLE decision
a_wr_key: assert property (@(posedge aclk) disable iff (!aresetn)
    (tbl_we && (state_q != ST_CLEAR)) |-> (tbl_addr == $past(tbl_addr, 2)));

endmodule

`default_nettype wire

// File: logic/rdma_flow_top.sv
`timescale 1ns/100ps
`default_nettype none

module rdma_flow_top
    import rdma_flow_pkg::*;
#(
    parameter int N_OST = 8,
    localparam int OST_BITS = $clog2(N_OST)
) (
    input  wire                 aclk,
    input  wire                 aresetn,

    input  wire                 s_req_valid,
    output logic                s_req_ready,
    input  wire                 s_req_rd,
    input  wire region_t        s_req_region,
    input  wire pid_t           s_req_pid,
    input  wire len_t           s_req_len,

    output logic                m_req_valid,
    input  wire                 m_req_ready,
    output logic                m_req_rd,
    output region_t             m_req_region,
    output pid_t                m_req_pid,
    output len_t                m_req_len,
    output logic [OST_BITS-1:0] m_req_offs,

    input  wire                 s_ack_valid,
    output logic                s_ack_ready,
    input  wire                 s_ack_rd,
    input  wire region_t        s_ack_region,
    input  wire pid_t           s_ack_pid,
    input  wire                 s_ack_last,

    output logic                m_ack_valid,
    input  wire                 m_ack_ready,
    output logic                m_ack_rd,
    output region_t             m_ack_region,
    output pid_t                m_ack_pid
);

// Queue words
localparam int RQ_WIDTH = 1 + REGION_BITS + PID_BITS + LEN_BITS + OST_BITS;
localparam int AQ_WIDTH = KEY_BITS;

logic tbl_we;
key_t tbl_addr;
ptr_word_t tbl_wdata;
ptr_word_t tbl_rdata;

logic rq_valid;
logic rq_ready;
logic [RQ_WIDTH-1:0] rq_data;
logic [RQ_WIDTH-1:0] rq_m_data;

logic aq_valid;
logic aq_ready;
logic [AQ_WIDTH-1:0] aq_data;
logic [AQ_WIDTH-1:0] aq_m_data;

rdma_flow #(
    .N_OST(N_OST)
) inst_flow (
    .aclk(aclk),
    .aresetn(aresetn),
    .s_req_valid(s_req_valid),
    .s_req_ready(s_req_ready),
    .s_req_rd(s_req_rd),
    .s_req_region(s_req_region),
    .s_req_pid(s_req_pid),
    .s_req_len(s_req_len),
    .s_ack_valid(s_ack_valid),
    .s_ack_ready(s_ack_ready),
    .s_ack_rd(s_ack_rd),
    .s_ack_region(s_ack_region),
    .s_ack_pid(s_ack_pid),
    .s_ack_last(s_ack_last),
    .tbl_we(tbl_we),
    .tbl_addr(tbl_addr),
    .tbl_wdata(tbl_wdata),
    .tbl_rdata(tbl_rdata),
    .rq_valid(rq_valid),
    .rq_ready(rq_ready),
    .rq_data(rq_data),
    .aq_valid(aq_valid),
    .aq_ready(aq_ready),
    .aq_data(aq_data)
);

// Only issued flag, head and tail are stored
ssn_table #(
    .ADDR_BITS(KEY_BITS),
    .DATA_BITS(2*OST_BITS + 1)
) inst_tbl (
    .aclk(aclk),
    .we(tbl_we),
    .addr(tbl_addr),
    .wdata(tbl_wdata),
    .rdata(tbl_rdata)
);

meta_queue #(
    .QDEPTH(N_OST),
    .WIDTH(RQ_WIDTH)
) inst_rq (
    .aclk(aclk),
    .aresetn(aresetn),
    .s_valid(rq_valid),
    .s_ready(rq_ready),
    .s_data(rq_data),
    .m_valid(m_req_valid),
    .m_ready(m_req_ready),
    .m_data(rq_m_data)
);

meta_queue #(
    .QDEPTH(N_OST),
    .WIDTH(AQ_WIDTH)
) inst_aq (
    .aclk(aclk),
    .aresetn(aresetn),
    .s_valid(aq_valid),
    .s_ready(aq_ready),
    .s_data(aq_data),
    .m_valid(m_ack_valid),
    .m_ready(m_ack_ready),
    .m_data(aq_m_data)
);

assign {m_req_rd, m_req_region, m_req_pid, m_req_len, m_req_offs} = rq_m_data;
assign {m_ack_rd, m_ack_region, m_ack_pid} = aq_m_data;

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD     = 40.0,
    parameter int  RST_CYCLES = 16
) (
    output logic aclk,
    output logic aresetn
);

initial begin
    aclk = 1'b0;
    forever #(PERIOD / 2.0) aclk = ~aclk;
end

// Release away from the rising edge
initial begin
    aresetn = 1'b0;
    repeat (RST_CYCLES) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
end

endmodule

`default_nettype wire

// File: tests/rdma_flow_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rdma_flow_tb
    import rdma_flow_pkg::*;
;

localparam int N_OST = 8;
localparam int OST_BITS = $clog2(N_OST);
localparam int N_RAND = 300;
localparam int N_TXN = N_RAND + 60;
localparam int LIMIT_CYCLES = N_TXN * 20 + 2 * 100 + 128 + 16;

typedef logic [OST_BITS-1:0] offs_t;
typedef struct packed {
    key_t  key;
    len_t  len;
    offs_t offs;
} req_exp_t;

logic aclk, aresetn;
logic s_req_valid, s_req_ready, s_req_rd;
region_t s_req_region;
pid_t s_req_pid;
len_t s_req_len;
logic m_req_valid, m_req_ready, m_req_rd;
region_t m_req_region;
pid_t m_req_pid;
len_t m_req_len;
offs_t m_req_offs;
logic s_ack_valid, s_ack_ready, s_ack_rd, s_ack_last;
region_t s_ack_region;
pid_t s_ack_pid;
logic m_ack_valid, m_ack_ready, m_ack_rd;
region_t m_ack_region;
pid_t m_ack_pid;

req_exp_t exp_req[$];
key_t exp_ack[$];
int outst[2**KEY_BITS];
int admits[2**KEY_BITS];
logic bp_en = 1'b0;

tb_clkgen #(.PERIOD(40.0), .RST_CYCLES(16)) inst_clk (.aclk(aclk), .aresetn(aresetn));

rdma_flow_top #(.N_OST(N_OST)) dut0 (
    .aclk(aclk), .aresetn(aresetn),
    .s_req_valid(s_req_valid), .s_req_ready(s_req_ready), .s_req_rd(s_req_rd),
    .s_req_region(s_req_region), .s_req_pid(s_req_pid), .s_req_len(s_req_len),
    .m_req_valid(m_req_valid), .m_req_ready(m_req_ready), .m_req_rd(m_req_rd),
    .m_req_region(m_req_region), .m_req_pid(m_req_pid), .m_req_len(m_req_len),
    .m_req_offs(m_req_offs),
    .s_ack_valid(s_ack_valid), .s_ack_ready(s_ack_ready), .s_ack_rd(s_ack_rd),
    .s_ack_region(s_ack_region), .s_ack_pid(s_ack_pid), .s_ack_last(s_ack_last),
    .m_ack_valid(m_ack_valid), .m_ack_ready(m_ack_ready), .m_ack_rd(m_ack_rd),
    .m_ack_region(m_ack_region), .m_ack_pid(m_ack_pid)
);

// Window model, offset is the running admit count modulo N_OST
function automatic offs_t ref_admit(input key_t k);
    offs_t offs;
    offs = offs_t'(admits[k] % N_OST);
    admits[k]++;
    outst[k]++;
    return offs;
endfunction

function automatic void ref_retire(input key_t k);
    outst[k]--;
endfunction

task automatic fail_now(input string msg);
    $display("%s at %0t", msg, $time);
    $display("TEST FAILED");
    $fatal(1, "stopped on first error");
endtask

task automatic report_diff(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
    $display("TEST FAILED");
    $fatal(1, "stopped on first error");
endtask

task automatic check_req(input key_t exp_key, input len_t exp_len, input offs_t exp_offs);
    key_t got_key;
    got_key = {m_req_rd, m_req_region, m_req_pid};
    if (got_key !== exp_key) report_diff("m_req key", exp_key, got_key);
    if (m_req_len !== exp_len) report_diff("m_req_len", exp_len, m_req_len);
    if (m_req_offs !== exp_offs) report_diff("m_req_offs", exp_offs, m_req_offs);
endtask

task automatic check_ack(input key_t exp_key);
    key_t got_key;
    got_key = {m_ack_rd, m_ack_region, m_ack_pid};
    if (got_key !== exp_key) report_diff("m_ack key", exp_key, got_key);
endtask

task automatic send_req(input key_t k, input len_t len);
    @(negedge aclk);
    s_req_valid = 1'b1;
    {s_req_rd, s_req_region, s_req_pid} = k;
    s_req_len = len;
    #1;
    while (!s_req_ready) begin
        @(negedge aclk);
        #1;
    end
    if (outst[k] >= N_OST) fail_now("request admitted on a full window");
    exp_req.push_back('{key: k, len: len, offs: ref_admit(k)});
    @(negedge aclk);
    s_req_valid = 1'b0;
endtask

task automatic send_ack(input key_t k, input logic last);
    @(negedge aclk);
    s_ack_valid = 1'b1;
    {s_ack_rd, s_ack_region, s_ack_pid} = k;
    s_ack_last = last;
    #1;
    while (!s_ack_ready) begin
        @(negedge aclk);
        #1;
    end
    ref_retire(k);
    if (last) exp_ack.push_back(k);
    @(negedge aclk);
    s_ack_valid = 1'b0;
endtask

// Present a request and require that it stays blocked
task automatic expect_blocked(input key_t k, input int cycles);
    @(negedge aclk);
    s_req_valid = 1'b1;
    {s_req_rd, s_req_region, s_req_pid} = k;
    s_req_len = 16'h0bad;
    repeat (cycles) begin
        #1;
        if (s_req_ready) fail_now("request admitted on a full window");
        @(negedge aclk);
    end
    s_req_valid = 1'b0;
endtask

// Random back-pressure on both outputs
always @(negedge aclk) begin
    m_req_ready <= bp_en ? 1'($urandom % 2) : 1'b1;
    m_ack_ready <= bp_en ? 1'($urandom % 2) : 1'b1;
end

always @(negedge aclk) begin
    req_exp_t e;
    #2;
    if (m_req_valid && m_req_ready) begin
        if (exp_req.size() == 0) fail_now("unexpected request on m_req");
        e = exp_req.pop_front();
        check_req(e.key, e.len, e.offs);
    end
    if (m_ack_valid && m_ack_ready) begin
        if (exp_ack.size() == 0) fail_now("unexpected ack on m_ack");
        check_ack(exp_ack.pop_front());
    end
end

initial begin
    repeat (LIMIT_CYCLES) @(posedge aclk);
    $display("TEST FAILED");
    $fatal(1, "Run timed out before all transactions finished");
end

initial begin
    key_t ka, kb, k;
    key_t pool[8];
    void'($urandom(32'h3860_32a4));
    {s_req_valid, s_req_rd, s_req_region, s_req_pid, s_req_len} = '0;
    {s_ack_valid, s_ack_rd, s_ack_region, s_ack_pid, s_ack_last} = '0;
    m_req_ready = 1'b1;
    m_ack_ready = 1'b1;
    @(posedge aresetn);

    // Offsets wrap and a full window blocks
    ka = {1'b0, 2'd1, 4'd3};
    kb = {1'b0, 2'd2, 4'd5};
    for (int i = 0; i < N_OST; i++) send_req(ka, len_t'(16'h100 + i));
    expect_blocked(ka, 100);
    send_req(kb, 16'h0042);
    // One last ack releases exactly one slot
    fork
        send_req(ka, 16'h0777);
        begin
            repeat (10) @(negedge aclk);
            send_ack(ka, 1'b1);
        end
    join
    expect_blocked(ka, 100);
    send_ack(kb, 1'b0);
    send_ack(ka, 1'b0);
    send_ack(ka, 1'b1);

    // Read and write windows of one region and pid
    for (int i = 0; i < 3; i++) begin
        send_req({1'b1, 2'd3, 4'd9}, len_t'(i));
        send_req({1'b0, 2'd3, 4'd9}, len_t'(16'h8000 + i));
    end

    for (int i = 0; i < 8; i++) pool[i] = key_t'($urandom);
    bp_en = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
        k = pool[$urandom % 8];
        if (outst[k] > 0 && ($urandom % 2 || outst[k] >= N_OST)) begin
            send_ack(k, 1'($urandom % 2));
        end else begin
            send_req(k, len_t'($urandom));
        end
    end

    bp_en = 1'b0;
    while (exp_req.size() != 0 || exp_ack.size() != 0) @(negedge aclk);
    repeat (5) @(negedge aclk);
    if (m_req_valid || m_ack_valid) fail_now("output left valid after the drain");
    $display("TEST OK");
    $finish;
end

endmodule

`default_nettype wire

// File: compile.f
logic/rdma_flow_pkg.sv
logic/ssn_table.sv
logic/meta_queue.sv
logic/rdma_flow.sv
logic/rdma_flow_top.sv
tests/tb_clkgen.sv
tests/rdma_flow_tb.sv

// File: Bender.yml
package:
  name: rdma_flow

sources:
  - logic/rdma_flow_pkg.sv
  - logic/ssn_table.sv
  - logic/meta_queue.sv
  - logic/rdma_flow.sv
  - logic/rdma_flow_top.sv
  - target: test
    files:
      - tests/tb_clkgen.sv
      - tests/rdma_flow_tb.sv
